// ==== flist.f ====
hist_pkg.sv
sample_sequencer.sv
bin_select.sv
histogram_ram.sv
peak_tracker.sv
hist_peak_top.sv
hist_peak_tb.sv

// ==== run.sh ====
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module hist_peak_tb \
    -o hist_peak_sim && ./obj_dir/hist_peak_sim || exit 1

// ==== hist_peak_tb.sv ====
`timescale 1ns/1ps

module hist_peak_tb;
    import hist_pkg::*;

    localparam int DRAIN_LIMIT = 200;

    logic                  clk;
    logic                  combin_res;
    logic                  hit_valid;
    logic [TDC_BITS-1:0]   hit_code;
    logic                  result_valid;
    logic [PIXEL_BITS-1:0] result_pixel;
    logic [TDC_BITS-1:0]   result_code;
    logic [CNT_BITS-1:0]   result_count;

    // reference model state
    logic [31:0]            lfsr;
    logic [TDC_BITS-1:0]    bias [PIXEL_NUM];
    logic [COARSE_BITS-1:0] model_coarse [PIXEL_NUM];

    // expected results in arrival order
    logic [PIXEL_BITS-1:0] exp_pixel_q [$];
    logic [TDC_BITS-1:0]   exp_code_q [$];
    logic [CNT_BITS-1:0]   exp_count_q [$];

    // result that should be on the outputs this cycle
    logic                  front_ok = 1'b0;
    logic [PIXEL_BITS-1:0] front_pixel;
    logic [TDC_BITS-1:0]   front_code;
    logic [CNT_BITS-1:0]   front_count;

    hist_peak_top i_hist_peak_top (
        .clk(clk), .combin_res(combin_res),
        .hit_valid(hit_valid), .hit_code(hit_code),
        .result_valid(result_valid), .result_pixel(result_pixel),
        .result_code(result_code), .result_count(result_count)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped");
    endtask

    // fibonacci lfsr with taps 32 22 2 1 stepped once per bit
    function automatic logic [7:0] next_bits(input int n);
        logic [7:0] v;
        logic       fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[6:0], fb};
        end
        return v;
    endfunction

    task automatic send_hit(input logic [TDC_BITS-1:0] code);
        @(posedge clk);
        hit_valid <= 1'b1;
        hit_code  <= code;
    endtask

    task automatic send_idle(input int n);
        repeat (n) begin
            @(posedge clk);
            hit_valid <= 1'b0;
        end
    endtask

    // mode 2 ties pixel 1 and mode 3 starves the last pixel in the fine pass
    function automatic logic [TDC_BITS-1:0] gen_code(input int p, input int d,
                                                     input int mode, input bit fine);
        logic [TDC_BITS-1:0] code;
        if (fine && mode == 3 && p == PIXEL_NUM - 1) begin
            // upper half never on the coarse peak
            code = {model_coarse[p] ^ 4'h8, 4'h0} | next_bits(4);
        end else if (mode == 2 && p == 1) begin
            // two bins tie on the final count and the first one wins
            code = (d == 0) ? bias[p] : bias[p] ^ (fine ? 8'h01 : 8'h40);
        end else if (next_bits(3) == 0) begin
            code = next_bits(8);
        end else begin
            code = bias[p] + next_bits(2);
        end
        return code;
    endfunction

    task automatic run_frame(input bit fine, input int mode);
        int                  hist [PIXEL_NUM][BIN_NUM];
        int                  max_c [PIXEL_NUM];
        logic [BIN_BITS-1:0] max_b [PIXEL_NUM];
        logic [TDC_BITS-1:0] code;
        logic [BIN_BITS-1:0] bin;
        for (int p = 0; p < PIXEL_NUM; p++) begin
            max_c[p] = 0;
            max_b[p] = '0;
            for (int b = 0; b < BIN_NUM; b++) begin
                hist[p][b] = 0;
            end
        end
        // same hit order as the sequencer counters
        for (int a = 0; a < ACQ_NUM; a++) begin
            for (int p = 0; p < PIXEL_NUM; p++) begin
                for (int d = 0; d < DATA_NUM; d++) begin
                    code = gen_code(p, d, mode, fine);
                    bin  = fine ? code[FINE_BITS-1:0] : code[TDC_BITS-1:FINE_BITS];
                    // fine hits only count on their pixel's coarse peak
                    if (!fine || code[TDC_BITS-1:FINE_BITS] == model_coarse[p]) begin
                        hist[p][bin]++;
                        if (hist[p][bin] > max_c[p]) begin
                            max_c[p] = hist[p][bin];
                            max_b[p] = bin;
                        end
                    end
                    send_hit(code);
                    // modes 1 and 2 send bursts and the others random gaps
                    if ((mode == 0 || mode == 3) && next_bits(2) == 0) begin
                        send_idle(next_bits(2));
                    end
                end
            end
        end
        for (int p = 0; p < PIXEL_NUM; p++) begin
            if (fine) begin
                exp_pixel_q.push_back(PIXEL_BITS'(p));
                exp_code_q.push_back({model_coarse[p], max_b[p]});
                exp_count_q.push_back(CNT_BITS'(max_c[p]));
            end else begin
                model_coarse[p] = max_b[p];
            end
        end
        if (!fine) begin
            // peak table needs the gap before fine hits arrive
            send_idle(FRAME_GAP);
        end
    endtask

    // advance past the result shown in the cycle that just ended
    always @(posedge clk) begin
        if (result_valid) begin
            if (exp_code_q.size() > 0) begin
                void'(exp_pixel_q.pop_front());
                void'(exp_code_q.pop_front());
                void'(exp_count_q.pop_front());
            end
        end
        front_ok <= (exp_code_q.size() > 0);
        if (exp_code_q.size() > 0) begin
            front_pixel <= exp_pixel_q[0];
            front_code  <= exp_code_q[0];
            front_count <= exp_count_q[0];
        end
    end

    // results are checked mid cycle away from the edges
    a_result_expected: assert property (@(negedge clk) disable iff (!combin_res)
        result_valid |-> front_ok)
        else stop_with_failure("result_valid high while no result was expected");
    a_result_pixel: assert property (@(negedge clk) disable iff (!combin_res)
        result_valid |-> (result_pixel == front_pixel))
        else stop_with_failure($sformatf("ERROR result_pixel got %h expected %h",
                                         result_pixel, front_pixel));
    a_result_code: assert property (@(negedge clk) disable iff (!combin_res)
        result_valid |-> (result_code == front_code))
        else stop_with_failure($sformatf("ERROR result_code got %h expected %h",
                                         result_code, front_code));
    a_result_count: assert property (@(negedge clk) disable iff (!combin_res)
        result_valid |-> (result_count == front_count))
        else stop_with_failure($sformatf("ERROR result_count got %h expected %h",
                                         result_count, front_count));
    a_result_gapless: assert property (@(negedge clk) disable iff (!combin_res)
        (result_valid && result_pixel != '0) |-> $past(result_valid))
        else stop_with_failure("results of one frame were not in consecutive cycles");
    a_result_burst: assert property (@(negedge clk) disable iff (!combin_res)
        (!result_valid && $past(result_valid)) |->
        ($past(result_pixel) == PIXEL_BITS'(PIXEL_NUM - 1)))
        else stop_with_failure("result burst ended before the last pixel");

    initial begin
        int waited;
        lfsr           = 32'h427c;
        combin_res     = 1'b0;
        hit_valid      = 1'b0;
        hit_code       = '0;
        for (int p = 0; p < PIXEL_NUM; p++) begin
            model_coarse[p] = '0;
        end
        repeat (3) @(posedge clk);
        combin_res <= 1'b1;
        // each round is a coarse frame then a fine frame
        for (int r = 0; r < 4; r++) begin
            for (int p = 0; p < PIXEL_NUM; p++) begin
                bias[p] = next_bits(8) & 8'hfc;
            end
            run_frame(1'b0, r);
            run_frame(1'b1, r);
        end
        send_idle(1);
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while ((exp_code_q.size() != 0 || result_valid) && waited < DRAIN_LIMIT);
        if (exp_code_q.size() != 0 || result_valid) begin
            stop_with_failure("timed out waiting for the last results");
        end else begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule

// ==== hist_peak_top.sv ====
`timescale 1ns/1ps

module hist_peak_top (
    input  logic                           clk,
    input  logic                           combin_res,
    input  logic                           hit_valid,
    input  logic [hist_pkg::TDC_BITS-1:0]   hit_code,
    output logic                           result_valid,
    output logic [hist_pkg::PIXEL_BITS-1:0] result_pixel,
    output logic [hist_pkg::TDC_BITS-1:0]   result_code,
    output logic [hist_pkg::CNT_BITS-1:0]   result_count
);
    import hist_pkg::*;

    // sequencer to bin select
    logic                  seq_valid;
    logic [TDC_BITS-1:0]   seq_code;
    logic [PIXEL_BITS-1:0] seq_pixel;
    pass_e                 seq_pass;
    logic                  seq_last;

    // bin select to counters
    logic                  sel_valid;
    logic [BIN_BITS-1:0]   sel_bin;
    logic [PIXEL_BITS-1:0] sel_pixel;
    pass_e                 sel_pass;
    logic                  sel_last;

    // counters to peak tracker
    logic                  cnt_valid;
    logic [CNT_BITS-1:0]   cnt_value;
    logic [BIN_BITS-1:0]   cnt_bin;
    logic [PIXEL_BITS-1:0] cnt_pixel;
    pass_e                 cnt_pass;
    logic                  cnt_last;

    // coarse peaks fed back for fine filtering
    logic [PIXEL_NUM*COARSE_BITS-1:0] coarse_table;

    sample_sequencer i_sample_sequencer (
        .clk(clk), .combin_res(combin_res),
        .hit_valid(hit_valid), .hit_code(hit_code),
        .seq_valid(seq_valid), .seq_code(seq_code), .seq_pixel(seq_pixel),
        .seq_pass(seq_pass), .seq_last(seq_last)
    );

    bin_select i_bin_select (
        .clk(clk), .combin_res(combin_res),
        .seq_valid(seq_valid), .seq_code(seq_code), .seq_pixel(seq_pixel),
        .seq_pass(seq_pass), .seq_last(seq_last), .coarse_table(coarse_table),
        .sel_valid(sel_valid), .sel_bin(sel_bin), .sel_pixel(sel_pixel),
        .sel_pass(sel_pass), .sel_last(sel_last)
    );

    histogram_ram i_histogram_ram (
        .clk(clk), .combin_res(combin_res),
        .sel_valid(sel_valid), .sel_bin(sel_bin), .sel_pixel(sel_pixel),
        .sel_pass(sel_pass), .sel_last(sel_last),
        .cnt_valid(cnt_valid), .cnt_value(cnt_value), .cnt_bin(cnt_bin),
        .cnt_pixel(cnt_pixel), .cnt_pass(cnt_pass), .cnt_last(cnt_last)
    );

    peak_tracker i_peak_tracker (
        .clk(clk), .combin_res(combin_res),
        .cnt_valid(cnt_valid), .cnt_value(cnt_value), .cnt_bin(cnt_bin),
        .cnt_pixel(cnt_pixel), .cnt_pass(cnt_pass), .cnt_last(cnt_last),
        .coarse_table(coarse_table),
        .result_valid(result_valid), .result_pixel(result_pixel),
        .result_code(result_code), .result_count(result_count)
    );

endmodule

// ==== peak_tracker.sv ====
`timescale 1ns/1ps

module peak_tracker (
    input  logic                           clk,
    input  logic                           combin_res,
    input  logic                           cnt_valid,
    input  logic [hist_pkg::CNT_BITS-1:0]   cnt_value,
    input  logic [hist_pkg::BIN_BITS-1:0]   cnt_bin,
    input  logic [hist_pkg::PIXEL_BITS-1:0] cnt_pixel,
    input  hist_pkg::pass_e                cnt_pass,
    input  logic                           cnt_last,
    output logic [hist_pkg::PIXEL_NUM*hist_pkg::COARSE_BITS-1:0] coarse_table,
    output logic                           result_valid,
    output logic [hist_pkg::PIXEL_BITS-1:0] result_pixel,
    output logic [hist_pkg::TDC_BITS-1:0]   result_code,
    output logic [hist_pkg::CNT_BITS-1:0]   result_count
);
    import hist_pkg::*;

    // running maximum per pixel
    logic [CNT_BITS-1:0] max_cnt [PIXEL_NUM];
    logic [BIN_BITS-1:0] max_bin [PIXEL_NUM];

    // coarse peak of each pixel from the last coarse frame
    logic [COARSE_BITS-1:0] table_q [PIXEL_NUM];

    // frame results held while they stream out
    logic [TDC_BITS-1:0] buf_code  [PIXEL_NUM];
    logic [CNT_BITS-1:0] buf_count [PIXEL_NUM];

    unload_e               unload_q;
    logic [PIXEL_BITS-1:0] unload_idx;

    // maxima with the current item folded in
    logic [CNT_BITS-1:0] fold_cnt [PIXEL_NUM];
    logic [BIN_BITS-1:0] fold_bin [PIXEL_NUM];
    logic                new_peak;

    // strictly greater, so the first bin to reach a count keeps it
    assign new_peak = cnt_valid && (cnt_value > max_cnt[cnt_pixel]);

    always_comb begin
        for (int p = 0; p < PIXEL_NUM; p++) begin
            fold_cnt[p] = max_cnt[p];
            fold_bin[p] = max_bin[p];
        end
        if (new_peak) begin
            fold_cnt[cnt_pixel] = cnt_value;
            fold_bin[cnt_pixel] = cnt_bin;
        end
    end

    always_comb begin
        for (int p = 0; p < PIXEL_NUM; p++) begin
            coarse_table[p*COARSE_BITS +: COARSE_BITS] = table_q[p];
        end
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            for (int p = 0; p < PIXEL_NUM; p++) begin
                max_cnt[p] <= '0;
                max_bin[p] <= '0;
                table_q[p] <= '0;
            end
        end else if (cnt_last) begin
            // frame end, coarse peaks latched and maxima restart
            for (int p = 0; p < PIXEL_NUM; p++) begin
                if (cnt_pass == PASS_COARSE) begin
                    table_q[p] <= fold_bin[p];
                end
                max_cnt[p] <= '0;
                max_bin[p] <= '0;
            end
        end else begin
            for (int p = 0; p < PIXEL_NUM; p++) begin
                max_cnt[p] <= fold_cnt[p];
                max_bin[p] <= fold_bin[p];
            end
        end
    end

    // unload FSM, one pixel per cycle from pixel 0
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            unload_q     <= UNLOAD_IDLE;
            unload_idx   <= '0;
            result_valid <= 1'b0;
        end else begin
            case (unload_q)
                UNLOAD_IDLE: begin
                    result_valid <= 1'b0;
                    if (cnt_last && cnt_pass == PASS_FINE) begin
                        unload_q   <= UNLOAD_RUN;
                        unload_idx <= '0;
                    end
                end
                UNLOAD_RUN: begin
                    result_valid <= 1'b1;
                    unload_idx   <= unload_idx + 1'b1;
                    if (unload_idx == PIXEL_BITS'(PIXEL_NUM - 1)) begin
                        unload_q <= UNLOAD_IDLE;
                    end
                end
                default: unload_q <= UNLOAD_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        // full peak code is coarse peak on top of fine peak
        if (cnt_last && cnt_pass == PASS_FINE) begin
            for (int p = 0; p < PIXEL_NUM; p++) begin
                buf_code[p]  <= {table_q[p], fold_bin[p]};
                buf_count[p] <= fold_cnt[p];
            end
        end
        if (unload_q == UNLOAD_RUN) begin
            result_pixel <= unload_idx;
            result_code  <= buf_code[unload_idx];
            result_count <= buf_count[unload_idx];
        end
    end

    // a fine frame is far longer than the unload, so it never overlaps
    a_unload_free: assert property (
        @(posedge clk) disable iff (!combin_res)
        (cnt_last && cnt_pass == PASS_FINE) |-> (unload_q == UNLOAD_IDLE)
    );

endmodule

// ==== histogram_ram.sv ====
`timescale 1ns/1ps

module histogram_ram (
    input  logic                           clk,
    input  logic                           combin_res,
    input  logic                           sel_valid,
    input  logic [hist_pkg::BIN_BITS-1:0]   sel_bin,
    input  logic [hist_pkg::PIXEL_BITS-1:0] sel_pixel,
    input  hist_pkg::pass_e                sel_pass,
    input  logic                           sel_last,
    output logic                           cnt_valid,
    output logic [hist_pkg::CNT_BITS-1:0]   cnt_value,
    output logic [hist_pkg::BIN_BITS-1:0]   cnt_bin,
    output logic [hist_pkg::PIXEL_BITS-1:0] cnt_pixel,
    output hist_pkg::pass_e                cnt_pass,
    output logic                           cnt_last
);
    import hist_pkg::*;

    // one counter per pixel and bin, pixel in the upper address bits
    logic [CNT_BITS-1:0] bin_mem [PIXEL_NUM*BIN_NUM];

    logic [PIXEL_BITS+BIN_BITS-1:0] mem_addr;
    logic [CNT_BITS-1:0]            bumped;

    assign mem_addr = {sel_pixel, sel_bin};
    assign bumped   = bin_mem[mem_addr] + 1'b1;

    // read-modify-write in one cycle, next hit sees the new count
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            for (int i = 0; i < PIXEL_NUM*BIN_NUM; i++) begin
                bin_mem[i] <= '0;
            end
        end else if (sel_last) begin
            // whole frame cleared, last hit is only reported
            for (int i = 0; i < PIXEL_NUM*BIN_NUM; i++) begin
                bin_mem[i] <= '0;
            end
        end else if (sel_valid) begin
            bin_mem[mem_addr] <= bumped;
        end
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            cnt_valid <= 1'b0;
            cnt_last  <= 1'b0;
            cnt_pixel <= '0;
            cnt_pass  <= PASS_COARSE;
        end else begin
            cnt_valid <= sel_valid;
            cnt_last  <= sel_last;
            if (sel_valid || sel_last) begin
                cnt_pixel <= sel_pixel;
                cnt_pass  <= sel_pass;
            end
        end
    end

    // updated count and its bin
    always_ff @(posedge clk) begin
        cnt_value <= bumped;
        cnt_bin   <= sel_bin;
    end

    // frame length keeps every bin below saturation
    a_no_wrap: assert property (
        @(posedge clk) disable iff (!combin_res)
        sel_valid |-> (bin_mem[mem_addr] != CNT_MAX)
    );

endmodule

// ==== bin_select.sv ====
`timescale 1ns/1ps

module bin_select (
    input  logic                                clk,
    input  logic                                combin_res,
    input  logic                                seq_valid,
    input  logic [hist_pkg::TDC_BITS-1:0]        seq_code,
    input  logic [hist_pkg::PIXEL_BITS-1:0]      seq_pixel,
    input  hist_pkg::pass_e                     seq_pass,
    input  logic                                seq_last,
    input  logic [hist_pkg::PIXEL_NUM*hist_pkg::COARSE_BITS-1:0] coarse_table,
    output logic                                sel_valid,
    output logic [hist_pkg::BIN_BITS-1:0]        sel_bin,
    output logic [hist_pkg::PIXEL_BITS-1:0]      sel_pixel,
    output hist_pkg::pass_e                     sel_pass,
    output logic                                sel_last
);
    import hist_pkg::*;

    logic [COARSE_BITS-1:0] code_coarse;
    logic [FINE_BITS-1:0]   code_fine;
    logic [COARSE_BITS-1:0] peak_coarse;
    logic                   peak_match;

    // split the code into its two halves
    assign code_coarse = seq_code[TDC_BITS-1:FINE_BITS];
    assign code_fine   = seq_code[FINE_BITS-1:0];

    // coarse peak latched for this pixel in the previous frame
    assign peak_coarse = coarse_table[seq_pixel*COARSE_BITS +: COARSE_BITS];
    assign peak_match  = (code_coarse == peak_coarse);

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            sel_valid <= 1'b0;
            sel_pixel <= '0;
            sel_pass  <= PASS_COARSE;
            sel_last  <= 1'b0;
        end else begin
            // fine hits off the coarse peak are not counted
            sel_valid <= seq_valid && ((seq_pass == PASS_COARSE) || peak_match);
            // frame end travels even when the hit itself is dropped
            sel_last  <= seq_valid && seq_last;
            if (seq_valid) begin
                sel_pixel <= seq_pixel;
                sel_pass  <= seq_pass;
            end
        end
    end

    // bin index, upper bits in coarse pass, lower bits in fine pass
    always_ff @(posedge clk) begin
        sel_bin <= (seq_pass == PASS_COARSE) ? code_coarse : code_fine;
    end

endmodule

// ==== sample_sequencer.sv ====
`timescale 1ns/1ps

module sample_sequencer (
    input  logic                         clk,
    input  logic                         combin_res,
    input  logic                         hit_valid,
    input  logic [hist_pkg::TDC_BITS-1:0] hit_code,
    output logic                         seq_valid,
    output logic [hist_pkg::TDC_BITS-1:0] seq_code,
    output logic [hist_pkg::PIXEL_BITS-1:0] seq_pixel,
    output hist_pkg::pass_e              seq_pass,
    output logic                         seq_last
);
    import hist_pkg::*;

    // position of the current hit inside the frame
    logic [DATA_BITS-1:0]  input_cnt;
    logic [PIXEL_BITS-1:0] pixel_cnt;
    logic [ACQ_BITS-1:0]   acq_cnt;
    pass_e                 pass_q;

    logic input_end;
    logic pixel_end;
    logic frame_end;

    // wrap flags for the three nested counters
    assign input_end = (input_cnt == DATA_BITS'(DATA_NUM - 1));
    assign pixel_end = (pixel_cnt == PIXEL_BITS'(PIXEL_NUM - 1));
    assign frame_end = input_end && pixel_end && (acq_cnt == ACQ_BITS'(ACQ_NUM - 1));

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            input_cnt <= '0;
            pixel_cnt <= '0;
            acq_cnt   <= '0;
            pass_q    <= PASS_COARSE;
            seq_valid <= 1'b0;
            seq_pixel <= '0;
            seq_pass  <= PASS_COARSE;
            seq_last  <= 1'b0;
        end else begin
            seq_valid <= hit_valid;
            seq_last  <= hit_valid && frame_end;
            if (hit_valid) begin
                // tag the hit with where it sits in the frame
                seq_pixel <= pixel_cnt;
                seq_pass  <= pass_q;
                if (input_end) begin
                    input_cnt <= '0;
                    if (pixel_end) begin
                        pixel_cnt <= '0;
                        if (frame_end) begin
                            // all counters back to zero at frame end
                            acq_cnt <= '0;
                            pass_q  <= (pass_q == PASS_COARSE) ? PASS_FINE : PASS_COARSE;
                        end else begin
                            acq_cnt <= acq_cnt + 1'b1;
                        end
                    end else begin
                        pixel_cnt <= pixel_cnt + 1'b1;
                    end
                end else begin
                    input_cnt <= input_cnt + 1'b1;
                end
            end
        end
    end

    // hit code passes straight through
    always_ff @(posedge clk) begin
        seq_code <= hit_code;
    end

    // pass only flips right after the closing hit of a frame
    a_pass_toggle: assert property (
        @(posedge clk) disable iff (!combin_res)
        (pass_q != $past(pass_q)) |-> seq_last
    );

    // fine frame must not start before the coarse peaks reach bin_select
    a_frame_gap: assert property (
        @(posedge clk) disable iff (!combin_res)
        (seq_last && seq_pass == PASS_COARSE) |-> !hit_valid [*FRAME_GAP]
    );

endmodule

// ==== hist_pkg.sv ====
package hist_pkg;

    // time code split into coarse and fine halves
    localparam int TDC_BITS    = 8;
    localparam int COARSE_BITS = 4;
    localparam int FINE_BITS   = 4;

    // one histogram per pixel, same bin count for both passes
    localparam int BIN_NUM  = 16;
    localparam int BIN_BITS = $clog2(BIN_NUM);

    // frame geometry, hits per pixel, then pixels, then acquisitions
    localparam int PIXEL_NUM  = 4;
    localparam int PIXEL_BITS = 2;
    localparam int DATA_NUM   = 2;
    localparam int DATA_BITS  = $clog2(DATA_NUM);
    localparam int ACQ_NUM    = 8;
    localparam int ACQ_BITS   = $clog2(ACQ_NUM);

    // bin counters, at most DATA_NUM*ACQ_NUM hits per bin per frame
    localparam int CNT_BITS = 8;
    localparam logic [CNT_BITS-1:0] CNT_MAX = '1;

    // idle input cycles after a coarse frame so the peak table settles
    localparam int FRAME_GAP = 4;

    // alternating frame passes
    typedef enum logic {
        PASS_COARSE,
        PASS_FINE
    } pass_e;

    // result streaming state
    typedef enum logic {
        UNLOAD_IDLE,
        UNLOAD_RUN
    } unload_e;

endpackage
